/* build.f */
logic/fib_pkg.sv
logic/fib_rx_parser.sv
logic/fib_valid_table.sv
logic/fib_lpm_search.sv
logic/fib_tx_serializer.sv
logic/fib_table.sv
sim/fib_table_tb.sv

/* logic/fib_lpm_search.sv */
// Longest-prefix search
// Walks the table from the requested length down, clearing one prefix bit per miss
// Holds the result until the output side takes it
module fib_lpm_search #(
    parameter int HASH_W = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  fib_pkg::prefix_t    req_prefix,
    input  fib_pkg::meta_t      req_meta,
    output logic                req_ready,
    output fib_pkg::len_t       rd_len,
    output logic [HASH_W-1:0]   rd_index,
    input  logic                rd_bit,
    output logic                res_valid,
    output fib_pkg::meta_t      res_meta,
    output fib_pkg::prefix_t    res_total,
    output fib_pkg::prefix_t    res_match,
    input  logic                res_ready
);

    fib_pkg::lpm_state_t state;
    fib_pkg::len_t       len;
    fib_pkg::meta_t      meta_q;
    fib_pkg::prefix_t    total_q;
    fib_pkg::prefix_t    work_q;
    fib_pkg::prefix_t    hash_full;
    logic                req_fire;
    logic                stop;

    assign req_ready = (state == fib_pkg::LPM_IDLE);
    assign req_fire  = req_valid && req_ready;

    // Hash of the current working prefix
    assign hash_full = fib_pkg::hash_prefix(work_q, HASH_W);

    // Table address follows the walk
    assign rd_len = len;

    // Walk ends on a hit or once length zero has been probed
    assign stop = rd_bit || (len == '0);

    // Result is held stable in LPM_DONE
    assign res_valid = (state == fib_pkg::LPM_DONE);
    assign res_meta  = meta_q;
    assign res_total = total_q;
    assign res_match = work_q;

    // Control FSM and length counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fib_pkg::LPM_IDLE;
            len   <= '0;
        end else begin
            case (state)
                fib_pkg::LPM_IDLE: begin
                    if (req_fire) begin
                        len   <= req_meta[fib_pkg::LEN_W-1:0];
                        state <= fib_pkg::LPM_HASH;
                    end
                end
                fib_pkg::LPM_HASH: state <= fib_pkg::LPM_READ;
                // Table registers rd_bit at the end of this cycle
                fib_pkg::LPM_READ: state <= fib_pkg::LPM_CHECK;
                fib_pkg::LPM_CHECK: begin
                    if (stop) begin
                        state <= fib_pkg::LPM_DONE;
                    end else begin
                        len   <= len - 1'b1;
                        state <= fib_pkg::LPM_HASH;
                    end
                end
                fib_pkg::LPM_DONE: begin
                    // Back-pressure from the serializer keeps us here
                    if (res_ready) begin
                        state <= fib_pkg::LPM_IDLE;
                    end
                end
                default: state <= fib_pkg::LPM_IDLE;
            endcase
        end
    end

    // Request capture, working prefix and probe index
    always_ff @(posedge clk) begin
        if (req_fire) begin
            meta_q  <= req_meta;
            total_q <= req_prefix;
            work_q  <= req_prefix;
        end
        if (state == fib_pkg::LPM_HASH) begin
            rd_index <= hash_full[HASH_W-1:0];
        end
        // Miss clears the bit at the current length position
        if (state == fib_pkg::LPM_CHECK && !stop) begin
            work_q[len] <= 1'b0;
        end
    end

    // A new probe after a miss has exactly one less length, never from zero
    assert property (@(posedge clk) disable iff (rst)
        (state == fib_pkg::LPM_HASH && $past(state) == fib_pkg::LPM_CHECK)
        |-> ($past(len) != '0) && (len == $past(len) - 1'b1));

endmodule

/* logic/fib_pkg.sv */
// Forwarding table shared definitions
// Widths, packet byte counts, FSM state types and the prefix hash
package fib_pkg;

    // Field widths
    localparam int PREFIX_W = 64;
    localparam int BYTE_W   = 8;
    localparam int LEN_W    = 6;

    // Byte counts on the streams
    // One metadata byte, then prefix bytes MSB first
    localparam int PREFIX_BYTES = PREFIX_W / BYTE_W;
    // Result carries metadata, requested prefix and matched prefix
    localparam int RESULT_BYTES = 1 + 2 * PREFIX_BYTES;

    typedef logic [PREFIX_W-1:0] prefix_t;
    typedef logic [BYTE_W-1:0]   meta_t;
    typedef logic [LEN_W-1:0]    len_t;

    // Learning parser states
    typedef enum logic [1:0] {
        RX_META,
        RX_PREFIX,
        RX_HASH,
        RX_WRITE
    } rx_state_t;

    // Longest-prefix walk states
    typedef enum logic [2:0] {
        LPM_IDLE,
        LPM_HASH,
        LPM_READ,
        LPM_CHECK,
        LPM_DONE
    } lpm_state_t;

    // Result serializer states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_META,
        TX_TOTAL,
        TX_MATCH
    } tx_state_t;

    // XOR fold of the prefix into hash_w wide chunks from bit 0 up
    // Last chunk is short, so its missing top bits act as zeros
    // Result sits in the low hash_w bits, upper bits stay zero
    function automatic prefix_t hash_prefix(input prefix_t prefix, input int unsigned hash_w);
        prefix_t folded;
        folded = '0;
        for (int i = 0; i < PREFIX_W; i++) begin
            folded[i % hash_w] = folded[i % hash_w] ^ prefix[i];
        end
        return folded;
    endfunction

endpackage

/* logic/fib_rx_parser.sv */
// Learning packet parser
// Collects metadata and prefix bytes, hashes the prefix, issues one table write
module fib_rx_parser #(
    parameter int HASH_W = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx_valid,
    input  fib_pkg::meta_t      rx_data,
    output logic                rx_ready,
    output logic                wr_en,
    output fib_pkg::len_t       wr_len,
    output logic [HASH_W-1:0]   wr_index
);

    localparam int CNT_W = $clog2(fib_pkg::PREFIX_BYTES);

    fib_pkg::rx_state_t state;
    logic [CNT_W-1:0]   byte_cnt;
    logic               rx_fire;
    fib_pkg::meta_t     meta_q;
    fib_pkg::prefix_t   prefix_q;
    fib_pkg::prefix_t   hash_full;

    // Ready only while bytes are being gathered
    assign rx_ready = (state == fib_pkg::RX_META) || (state == fib_pkg::RX_PREFIX);
    assign rx_fire  = rx_valid && rx_ready;

    // Write strobe is one cycle, right after the hash register loads
    assign wr_en  = (state == fib_pkg::RX_WRITE);
    assign wr_len = meta_q[fib_pkg::LEN_W-1:0];

    assign hash_full = fib_pkg::hash_prefix(prefix_q, HASH_W);

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fib_pkg::RX_META;
            byte_cnt <= '0;
        end else begin
            case (state)
                fib_pkg::RX_META: begin
                    if (rx_fire) begin
                        byte_cnt <= CNT_W'(fib_pkg::PREFIX_BYTES - 1);
                        state    <= fib_pkg::RX_PREFIX;
                    end
                end
                fib_pkg::RX_PREFIX: begin
                    if (rx_fire) begin
                        // Count hits zero on the last prefix byte
                        if (byte_cnt == '0) begin
                            state <= fib_pkg::RX_HASH;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                        end
                    end
                end
                fib_pkg::RX_HASH:  state <= fib_pkg::RX_WRITE;
                fib_pkg::RX_WRITE: state <= fib_pkg::RX_META;
                default:           state <= fib_pkg::RX_META;
            endcase
        end
    end

    // Packet payload and hash register
    always_ff @(posedge clk) begin
        if (rx_fire && state == fib_pkg::RX_META) begin
            meta_q <= rx_data;
        end
        // Shift in MSB first
        if (rx_fire && state == fib_pkg::RX_PREFIX) begin
            prefix_q <= {prefix_q[fib_pkg::PREFIX_W-fib_pkg::BYTE_W-1:0], rx_data};
        end
        if (state == fib_pkg::RX_HASH) begin
            wr_index <= hash_full[HASH_W-1:0];
        end
    end

    // Write lands two cycles after the last accepted byte and the stream stays stalled meanwhile
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !rx_ready && !$past(rx_ready) && $past(rx_fire, 2));

endmodule

/* logic/fib_table.sv */
// Forwarding table top level
// Learning parser and valid-bit table on one side, LPM search and result stream on the other
module fib_table #(
    parameter int HASH_W = 10
) (
    input  logic                clk,
    input  logic                rst,

    // Learning stream
    input  logic                rx_valid,
    input  fib_pkg::meta_t      rx_data,
    output logic                rx_ready,

    // Lookup request
    input  logic                req_valid,
    input  fib_pkg::prefix_t    req_prefix,
    input  fib_pkg::meta_t      req_meta,
    output logic                req_ready,

    // Result stream
    output logic                tx_valid,
    output fib_pkg::meta_t      tx_data,
    input  logic                tx_ready
);

    // Parser to table
    logic                wr_en;
    fib_pkg::len_t       wr_len;
    logic [HASH_W-1:0]   wr_index;

    // Search to table
    fib_pkg::len_t       rd_len;
    logic [HASH_W-1:0]   rd_index;
    logic                rd_bit;

    // Search to serializer
    logic                res_valid;
    logic                res_ready;
    fib_pkg::meta_t      res_meta;
    fib_pkg::prefix_t    res_total;
    fib_pkg::prefix_t    res_match;

    fib_rx_parser #(
        .HASH_W   (HASH_W)
    ) u_rx_parser (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_ready (rx_ready),
        .wr_en    (wr_en),
        .wr_len   (wr_len),
        .wr_index (wr_index)
    );

    fib_valid_table #(
        .HASH_W   (HASH_W)
    ) u_valid_table (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_len   (wr_len),
        .wr_index (wr_index),
        .rd_len   (rd_len),
        .rd_index (rd_index),
        .rd_bit   (rd_bit)
    );

    fib_lpm_search #(
        .HASH_W     (HASH_W)
    ) u_lpm_search (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_prefix (req_prefix),
        .req_meta   (req_meta),
        .req_ready  (req_ready),
        .rd_len     (rd_len),
        .rd_index   (rd_index),
        .rd_bit     (rd_bit),
        .res_valid  (res_valid),
        .res_meta   (res_meta),
        .res_total  (res_total),
        .res_match  (res_match),
        .res_ready  (res_ready)
    );

    fib_tx_serializer u_tx_serializer (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res_meta  (res_meta),
        .res_total (res_total),
        .res_match (res_match),
        .res_ready (res_ready),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready)
    );

endmodule

/* logic/fib_tx_serializer.sv */
// Result serializer
// Sends metadata, requested prefix, then matched prefix, MSB first, under valid/ready
module fib_tx_serializer (
    input  logic                clk,
    input  logic                rst,
    input  logic                res_valid,
    input  fib_pkg::meta_t      res_meta,
    input  fib_pkg::prefix_t    res_total,
    input  fib_pkg::prefix_t    res_match,
    output logic                res_ready,
    output logic                tx_valid,
    output fib_pkg::meta_t      tx_data,
    input  logic                tx_ready
);

    localparam int CNT_W = $clog2(fib_pkg::RESULT_BYTES);
    localparam int SEL_W = $clog2(fib_pkg::PREFIX_BYTES);

    fib_pkg::tx_state_t state;
    logic [CNT_W-1:0]   byte_cnt;
    logic [SEL_W-1:0]   byte_sel;
    logic               tx_fire;
    fib_pkg::meta_t     meta_q;
    fib_pkg::prefix_t   total_q;
    fib_pkg::prefix_t   match_q;

    // Only one result in flight
    assign res_ready = (state == fib_pkg::TX_IDLE);
    assign tx_valid  = (state != fib_pkg::TX_IDLE);
    assign tx_fire   = tx_valid && tx_ready;

    // byte_cnt counts bytes already sent; map it to a byte lane, MSB first
    always_comb begin
        case (state)
            fib_pkg::TX_TOTAL: byte_sel = SEL_W'(fib_pkg::PREFIX_BYTES - byte_cnt);
            fib_pkg::TX_MATCH: byte_sel = SEL_W'(fib_pkg::RESULT_BYTES - 1 - byte_cnt);
            default:           byte_sel = '0;
        endcase
    end

    always_comb begin
        case (state)
            fib_pkg::TX_META:  tx_data = meta_q;
            fib_pkg::TX_TOTAL: tx_data = total_q[byte_sel*fib_pkg::BYTE_W +: fib_pkg::BYTE_W];
            fib_pkg::TX_MATCH: tx_data = match_q[byte_sel*fib_pkg::BYTE_W +: fib_pkg::BYTE_W];
            default:           tx_data = '0;
        endcase
    end

    // Control FSM with running byte count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fib_pkg::TX_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                fib_pkg::TX_IDLE: begin
                    byte_cnt <= '0;
                    if (res_valid) begin
                        state <= fib_pkg::TX_META;
                    end
                end
                fib_pkg::TX_META: begin
                    if (tx_fire) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= fib_pkg::TX_TOTAL;
                    end
                end
                fib_pkg::TX_TOTAL: begin
                    if (tx_fire) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == CNT_W'(fib_pkg::PREFIX_BYTES)) begin
                            state <= fib_pkg::TX_MATCH;
                        end
                    end
                end
                fib_pkg::TX_MATCH: begin
                    if (tx_fire) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        // Last of the 17 bytes
                        if (byte_cnt == CNT_W'(fib_pkg::RESULT_BYTES - 1)) begin
                            state <= fib_pkg::TX_IDLE;
                        end
                    end
                end
                default: state <= fib_pkg::TX_IDLE;
            endcase
        end
    end

    // Result copy taken on the load handshake
    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            meta_q  <= res_meta;
            total_q <= res_total;
            match_q <= res_match;
        end
    end

    // Stalled byte must not change or drop
    assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> tx_valid && $stable(tx_data));

endmodule

/* logic/fib_valid_table.sv */
// Valid-bit store of the forwarding table
// One row per prefix length, each row indexed by prefix hash
// Single write port and one registered read port
module fib_valid_table #(
    parameter int HASH_W = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  fib_pkg::len_t       wr_len,
    input  logic [HASH_W-1:0]   wr_index,
    input  fib_pkg::len_t       rd_len,
    input  logic [HASH_W-1:0]   rd_index,
    output logic                rd_bit
);

    localparam int ROWS  = 2 ** fib_pkg::LEN_W;
    localparam int ROW_W = 2 ** HASH_W;

    // One bit per (length, hash) pair
    logic [ROW_W-1:0] rows [ROWS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Empty table, nothing learned
            for (int r = 0; r < ROWS; r++) begin
                rows[r] <= '0;
            end
            rd_bit <= 1'b0;
        end else begin
            // Entries are only ever set, never cleared
            if (wr_en) begin
                rows[wr_len][wr_index] <= 1'b1;
            end
            // Nonblocking read sees the pre-write value
            rd_bit <= rows[rd_len][rd_index];
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the forwarding table testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module fib_table_tb -Mdir "$BUILD_DIR" -o fib_table_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/fib_table_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
    exit 0
fi
exit 1

/* sim/fib_table_tb.sv */
// Forwarding table testbench
// Learns prefixes, runs lookups and checks every result byte against a reference walk
module fib_table_tb;

    localparam int HASH_W    = 10;
    localparam int RES_BITS  = fib_pkg::RESULT_BYTES * fib_pkg::BYTE_W;
    localparam int PKT_BYTES = 1 + fib_pkg::PREFIX_BYTES;
    localparam int N_LEARN   = 11;
    localparam int N_LOOKUPS = 23;
    // Full walk is 64 probes of 3 cycles, streams may stall up to 4x per byte
    localparam int TIMEOUT_CYCLES = N_LOOKUPS * 64 * 3
        + (N_LEARN * PKT_BYTES + N_LOOKUPS * fib_pkg::RESULT_BYTES) * 4 + 2000;

    logic             clk;
    logic             rst;
    logic             rx_valid;
    fib_pkg::meta_t   rx_data;
    logic             rx_ready;
    logic             req_valid;
    fib_pkg::prefix_t req_prefix;
    fib_pkg::meta_t   req_meta;
    logic             req_ready;
    logic             tx_valid;
    fib_pkg::meta_t   tx_data;
    logic             tx_ready;

    int               errors;
    bit               use_gaps;
    bit               ready_random;
    int               out_idx;
    // Reference table, keyed by length and hash
    bit               learned [int];
    logic [7:0]       exp_q [$];
    string            name_q [$];
    logic [7:0]       exp_byte;
    string            exp_name;
    logic [63:0]      known_pfx [$];
    logic [7:0]       known_meta [$];
    logic [63:0]      pfx;
    int               pick;
    int               long_len [3]   = '{12, 25, 33};
    int               long_start [5] = '{40, 33, 30, 20, 8};

    fib_table #(
        .HASH_W     (HASH_W)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_ready   (rx_ready),
        .req_valid  (req_valid),
        .req_prefix (req_prefix),
        .req_meta   (req_meta),
        .req_ready  (req_ready),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_ready   (tx_ready)
    );

    always #10 clk = ~clk;

    // XOR of HASH_W wide chunks, zeros shift in above the last short chunk
    function automatic logic [HASH_W-1:0] ref_hash(input logic [63:0] prefix);
        logic [HASH_W-1:0] h;
        logic [63:0]       rest;
        h = '0;
        rest = prefix;
        for (int base = 0; base < 64; base += HASH_W) begin
            h = h ^ rest[HASH_W-1:0];
            rest = rest >> HASH_W;
        end
        return h;
    endfunction

    function automatic int table_key(input int len, input logic [HASH_W-1:0] h);
        return len * (1 << HASH_W) + int'(h);
    endfunction

    // Expected 17 bytes: metadata, requested prefix, prefix where the walk stopped
    function automatic logic [RES_BITS-1:0] expected_result(input logic [7:0] meta,
                                                            input logic [63:0] prefix);
        logic [63:0] work;
        int          len;
        work = prefix;
        len = int'(meta[5:0]);
        while (len > 0 && !learned.exists(table_key(len, ref_hash(work)))) begin
            work[len] = 1'b0;
            len--;
        end
        return {meta, prefix, work};
    endfunction

    function automatic logic [63:0] random_prefix();
        return {$urandom, $urandom};
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // One learning packet, optional gaps before each byte
    task automatic send_learn(input logic [7:0] meta, input logic [63:0] prefix);
        logic [PKT_BYTES*8-1:0] pkt;
        pkt = {meta, prefix};
        for (int i = 0; i < PKT_BYTES; i++) begin
            if (use_gaps) idle_cycles($urandom_range(3));
            rx_valid = 1'b1;
            rx_data = pkt[PKT_BYTES*8-1-8*i -: 8];
            @(negedge clk);
            while (!rx_ready) @(negedge clk);
            idle_cycles(1);
            rx_valid = 1'b0;
        end
        learned[table_key(int'(meta[5:0]), ref_hash(prefix))] = 1'b1;
    endtask

    // Expected bytes are queued when the request is accepted
    task automatic send_lookup(input string name, input logic [7:0] meta,
                               input logic [63:0] prefix);
        logic [RES_BITS-1:0] res;
        if (use_gaps) idle_cycles($urandom_range(3));
        req_valid = 1'b1;
        req_meta = meta;
        req_prefix = prefix;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        res = expected_result(meta, prefix);
        for (int i = 0; i < fib_pkg::RESULT_BYTES; i++) begin
            exp_q.push_back(res[RES_BITS-1-8*i -: 8]);
            name_q.push_back(name);
        end
        idle_cycles(1);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        idle_cycles(4);
    endtask

    // Random stalls on the result stream
    always @(posedge clk) begin
        #2;
        tx_ready = ready_random ? ($urandom_range(3) != 0) : 1'b1;
    end

    // Compare each result byte, sampled mid-cycle ahead of its transfer edge
    always @(negedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            if (exp_q.size() == 0) begin
                $display("Result byte 0x%02h was sent while no lookup was pending", tx_data);
                errors++;
            end else begin
                exp_byte = exp_q.pop_front();
                exp_name = name_q.pop_front();
                if (tx_data !== exp_byte) begin
                    $display("** Error [%s] byte %0d: expected 0x%02h, actual 0x%02h",
                             exp_name, out_idx, exp_byte, tx_data);
                    errors++;
                end
                out_idx = (out_idx + 1) % fib_pkg::RESULT_BYTES;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish in %0d cycles, %0d errors", TIMEOUT_CYCLES, errors);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(32'h4d3d_e0cf));
        clk = 1'b0;
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_data = '0;
        req_valid = 1'b0;
        req_prefix = '0;
        req_meta = '0;
        tx_ready = 1'b1;
        errors = 0;
        out_idx = 0;
        use_gaps = 1'b0;
        ready_random = 1'b0;
        idle_cycles(4);
        rst = 1'b0;

        // Handshakes idle after reset
        @(negedge clk);
        if (tx_valid !== 1'b0 || rx_ready !== 1'b1 || req_ready !== 1'b1) begin
            $display("Handshake outputs not idle after reset: tx_valid %b rx_ready %b req_ready %b",
                     tx_valid, rx_ready, req_ready);
            errors++;
        end
        idle_cycles(1);

        // Nothing learned, every walk runs to length zero
        for (int i = 0; i < 3; i++) begin
            send_lookup("empty_table", 8'($urandom), random_prefix());
        end
        wait_drain();

        for (int i = 0; i < 4; i++) begin
            known_pfx.push_back(random_prefix());
            known_meta.push_back(8'($urandom));
            send_learn(known_meta[i], known_pfx[i]);
        end
        idle_cycles(6);
        for (int i = 0; i < 4; i++) begin
            send_lookup("exact_hit", known_meta[i], known_pfx[i]);
        end
        wait_drain();

        // Masked copies at several lengths, bits above 40 kept clear
        pfx = random_prefix() & 64'h0000_01ff_ffff_ffff;
        foreach (long_len[k]) begin
            send_learn(8'(long_len[k]), pfx & ((64'h1 << (long_len[k] + 1)) - 1));
        end
        idle_cycles(6);
        // Each lookup prefix carries no bits above its start length
        foreach (long_start[k]) begin
            send_lookup("longest_match", {2'($urandom_range(3)), 6'(long_start[k])},
                        pfx & ((64'h1 << (long_start[k] + 1)) - 1));
        end
        wait_drain();

        // Gaps on both inputs and stalls on the output
        use_gaps = 1'b1;
        ready_random = 1'b1;
        for (int i = 0; i < 4; i++) begin
            known_pfx.push_back(random_prefix());
            known_meta.push_back(8'($urandom));
            send_learn(known_meta[4+i], known_pfx[4+i]);
        end
        idle_cycles(6);
        for (int i = 0; i < 6; i++) begin
            pick = $urandom_range(known_pfx.size() - 1);
            if (i % 2 == 0) begin
                send_lookup("back_pressure", known_meta[pick], known_pfx[pick]);
            end else begin
                send_lookup("back_pressure", 8'($urandom), random_prefix());
            end
        end
        wait_drain();

        // Next request offered while the previous result streams
        use_gaps = 1'b0;
        for (int i = 0; i < 5; i++) begin
            pick = $urandom_range(known_pfx.size() - 1);
            if (i % 2 == 0) begin
                send_lookup("back_to_back", known_meta[pick], known_pfx[pick]);
            end else begin
                send_lookup("back_to_back", 8'($urandom), random_prefix());
            end
        end
        wait_drain();

        $display("Run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
